/* Makefile */
# Verilator build of the execute subsystem testbench

VERILATOR ?= verilator
TOP       ?= exu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Testbench passed" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
hdl/exu_pkg.sv
hdl/exu_alu.sv
hdl/exu_mult.sv
hdl/exu_issue_stage.sv
hdl/exu_ex_stage.sv
hdl/exu_wb_stage.sv
hdl/exu_top.sv
verif/exu_tb.sv

/* hdl/exu_alu.sv */
`default_nettype none

module exu_alu
(
  input  exu_pkg::exu_op_e operator_i,
  input  exu_pkg::word_t   operand_a_i,
  input  exu_pkg::word_t   operand_b_i,
  output exu_pkg::word_t   result_o,
  output logic             cmp_flag_o
);

  exu_pkg::shamt_t shamt;
  exu_pkg::word_t  sum;
  exu_pkg::word_t  diff;
  logic            lt_signed;
  logic            lt_unsigned;
  logic            equal;

  // Shift amount from the low bits of operand B
  assign shamt = operand_b_i[exu_pkg::SHAMT_W-1:0];

  // Adder and subtractor
  assign sum  = operand_a_i + operand_b_i;
  assign diff = operand_a_i - operand_b_i;

  // Comparators
  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_unsigned = operand_a_i < operand_b_i;
  assign equal       = (operand_a_i == operand_b_i);

  //////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////

  always_comb
  begin
    result_o   = '0;
    cmp_flag_o = 1'b0;
    case (operator_i)
      exu_pkg::ADD: result_o = sum;
      exu_pkg::SUB: result_o = diff;
      exu_pkg::AND: result_o = operand_a_i & operand_b_i;
      exu_pkg::OR:  result_o = operand_a_i | operand_b_i;
      exu_pkg::XOR: result_o = operand_a_i ^ operand_b_i;
      exu_pkg::SLL: result_o = operand_a_i << shamt;
      exu_pkg::SRL: result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign bit
      exu_pkg::SRA: result_o = $signed(operand_a_i) >>> shamt;
      // Compares give 1 or 0 and the same truth on the flag
      exu_pkg::SLT:
      begin
        result_o   = {31'b0, lt_signed};
        cmp_flag_o = lt_signed;
      end
      exu_pkg::SLTU:
      begin
        result_o   = {31'b0, lt_unsigned};
        cmp_flag_o = lt_unsigned;
      end
      exu_pkg::EQ:
      begin
        result_o   = {31'b0, equal};
        cmp_flag_o = equal;
      end
      // Multiplier operators are not handled here
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/exu_ex_stage.sv */
`default_nettype none

module exu_ex_stage
(
  input  logic                 clk,
  input  logic                 rst_n,

  // ID/EX pipeline
  input  exu_pkg::id_ex_pipe_t id_ex_pipe_i,
  output logic                 ex_ready_o,

  // EX/WB pipeline
  input  logic                 wb_ready_i,
  output exu_pkg::ex_wb_pipe_t ex_wb_pipe_o
);

  exu_pkg::word_t alu_result;
  logic           alu_cmp;
  exu_pkg::word_t mult_result;
  logic           mult_done;
  logic           mult_ready;
  logic           accept;
  logic           alu_fire;
  logic           mult_start;
  logic           load;
  logic           ex_wb_valid_q;
  exu_pkg::tag_t  ex_wb_tag_q;
  exu_pkg::word_t ex_wb_data_q;
  logic           ex_wb_cmp_q;
  exu_pkg::tag_t  mult_tag_q;

  exu_alu i_alu
  (
    .operator_i  ( id_ex_pipe_i.operator  ),
    .operand_a_i ( id_ex_pipe_i.operand_a ),
    .operand_b_i ( id_ex_pipe_i.operand_b ),
    .result_o    ( alu_result             ),
    .cmp_flag_o  ( alu_cmp                )
  );

  exu_mult i_mult
  (
    .clk        ( clk                    ),
    .rst_n      ( rst_n                  ),
    .start_i    ( mult_start             ),
    .operator_i ( id_ex_pipe_i.operator  ),
    .op_a_i     ( id_ex_pipe_i.operand_a ),
    .op_b_i     ( id_ex_pipe_i.operand_b ),
    .result_o   ( mult_result            ),
    .done_o     ( mult_done              ),
    .ready_o    ( mult_ready             )
  );

  // Ready needs an idle multiplier and room in EX/WB
  // A started multiply thus always finds EX/WB empty at done
  assign ex_ready_o = mult_ready && (!ex_wb_valid_q || wb_ready_i);

  assign accept     = id_ex_pipe_i.valid && ex_ready_o;
  assign alu_fire   = accept && id_ex_pipe_i.alu_en;
  assign mult_start = accept && id_ex_pipe_i.mult_en;
  // Never both, the multiplier holds ready low during done
  assign load       = alu_fire || mult_done;

  //////////////////////////////////////////////////
  // EX/WB pipeline register
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      ex_wb_valid_q <= 1'b0;
    else if (load)
      ex_wb_valid_q <= 1'b1;
    else if (wb_ready_i)
      ex_wb_valid_q <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    // Tag waits here while the multiplier iterates
    if (mult_start)
      mult_tag_q <= id_ex_pipe_i.tag;
    if (load)
    begin
      ex_wb_tag_q  <= mult_done ? mult_tag_q : id_ex_pipe_i.tag;
      ex_wb_data_q <= mult_done ? mult_result : alu_result;
      ex_wb_cmp_q  <= !mult_done && alu_cmp;
    end
  end

  assign ex_wb_pipe_o = '{
    valid:    ex_wb_valid_q,
    tag:      ex_wb_tag_q,
    data:     ex_wb_data_q,
    cmp_flag: ex_wb_cmp_q
  };

endmodule

`default_nettype wire

/* hdl/exu_issue_stage.sv */
`default_nettype none

module exu_issue_stage
(
  input  logic                 clk,
  input  logic                 rst_n,

  // Four-phase request port
  input  logic                 op_req_i,
  input  exu_pkg::exu_req_t    op_i,
  output logic                 op_ack_o,

  // ID/EX pipeline
  input  logic                 ex_ready_i,
  output exu_pkg::id_ex_pipe_t id_ex_pipe_o
);

  typedef enum logic [1:0] {IDLE, ACK, WAIT_LOW} hs_state_e;

  hs_state_e         state_q;
  hs_state_e         state_d;
  logic              slot_valid_q;
  logic              capture;
  logic              is_mult;
  exu_pkg::exu_req_t slot_q;

  // Take a new operation only with the handshake idle and the slot free
  assign capture = (state_q == IDLE) && op_req_i && !slot_valid_q;

  //////////////////////////////////////////////////
  // Four-phase receive FSM
  //////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:     if (capture) state_d = ACK;
      // Ack is up, requester still holds req
      ACK:      state_d = WAIT_LOW;
      // Ack drops together with the return to IDLE
      WAIT_LOW: if (!op_req_i) state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q      <= IDLE;
      slot_valid_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (capture)
        slot_valid_q <= 1'b1;
      else if (slot_valid_q && ex_ready_i)
        slot_valid_q <= 1'b0;
    end
  end

  // Holding register, payload only
  always_ff @(posedge clk)
  begin
    if (capture)
      slot_q <= op_i;
  end

  assign op_ack_o = (state_q != IDLE);

  // Decode into unit enables
  assign is_mult = slot_q.operator inside {exu_pkg::MUL, exu_pkg::MULH, exu_pkg::MULHU};

  assign id_ex_pipe_o = '{
    valid:     slot_valid_q,
    alu_en:    slot_valid_q && !is_mult,
    mult_en:   slot_valid_q && is_mult,
    operator:  slot_q.operator,
    operand_a: slot_q.operand_a,
    operand_b: slot_q.operand_b,
    tag:       slot_q.tag
  };

endmodule

`default_nettype wire

/* hdl/exu_mult.sv */
`default_nettype none

module exu_mult
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start_i,
  input  exu_pkg::exu_op_e operator_i,
  input  exu_pkg::word_t   op_a_i,
  input  exu_pkg::word_t   op_b_i,
  output exu_pkg::word_t   result_o,
  output logic             done_o,
  output logic             ready_o
);

  logic                busy_q;
  logic                done_q;
  exu_pkg::mult_cnt_t  cnt_q;
  logic                signed_mode;
  exu_pkg::word_t      mag_a;
  exu_pkg::word_t      mag_b;
  logic [63:0]         mcand_q;
  logic [63:0]         acc_q;
  logic [63:0]         partial;
  logic [63:0]         product;
  exu_pkg::word_t      mplier_q;
  logic                neg_q;
  exu_pkg::exu_op_e    op_q;

  // Only MULH treats both operands as signed
  assign signed_mode = (operator_i == exu_pkg::MULH);
  assign mag_a = (signed_mode && op_a_i[31]) ? -op_a_i : op_a_i;
  assign mag_b = (signed_mode && op_b_i[31]) ? -op_b_i : op_b_i;

  // Radix-4 digit times the shifted multiplicand
  always_comb
  begin
    case (mplier_q[1:0])
      2'd1:    partial = mcand_q;
      2'd2:    partial = mcand_q << 1;
      2'd3:    partial = mcand_q + (mcand_q << 1);
      default: partial = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Iteration control
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end
    else
    begin
      done_q <= 1'b0;
      if (start_i && ready_o)
      begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end
      else if (busy_q)
      begin
        cnt_q <= cnt_q + 1'b1;
        // Last digit consumed, result valid next cycle
        if (cnt_q == exu_pkg::MULT_LAST)
        begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // Data path registers
  always_ff @(posedge clk)
  begin
    if (start_i && ready_o)
    begin
      acc_q    <= '0;
      mcand_q  <= {32'b0, mag_a};
      mplier_q <= mag_b;
      neg_q    <= signed_mode && (op_a_i[31] ^ op_b_i[31]);
      op_q     <= operator_i;
    end
    else if (busy_q)
    begin
      acc_q    <= acc_q + partial;
      mcand_q  <= mcand_q << 2;
      mplier_q <= mplier_q >> 2;
    end
  end

  // Sign fix on the full product, then half select
  assign product  = neg_q ? -acc_q : acc_q;
  assign result_o = (op_q == exu_pkg::MUL) ? product[31:0] : product[63:32];

  assign done_o  = done_q;
  // Idle means neither iterating nor presenting a result
  assign ready_o = !busy_q && !done_q;

endmodule

`default_nettype wire

/* hdl/exu_pkg.sv */
`default_nettype none

package exu_pkg;

  //////////////////////////////////////////////////
  // Widths and constants
  //////////////////////////////////////////////////

  // Data path width
  localparam int unsigned WORD_W = 32;
  // Destination tag width
  localparam int unsigned TAG_W = 5;
  // Shift amount comes from the low bits of operand B
  localparam int unsigned SHAMT_W = 5;
  // Radix-4 iteration count for a 32-bit multiplier
  localparam int unsigned MULT_STEPS = 16;
  localparam int unsigned MULT_CNT_W = $clog2(MULT_STEPS);

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [SHAMT_W-1:0]    shamt_t;
  typedef logic [MULT_CNT_W-1:0] mult_cnt_t;

  // Counter value of the final multiplier step
  localparam mult_cnt_t MULT_LAST = mult_cnt_t'(MULT_STEPS - 1);

  //////////////////////////////////////////////////
  // Operators
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR,
    SLL, SRL, SRA,
    SLT, SLTU, EQ,
    MUL, MULH, MULHU
  } exu_op_e;

  //////////////////////////////////////////////////
  // Port payloads and pipeline registers
  //////////////////////////////////////////////////

  // Input port payload, 73 bits
  typedef struct packed {
    exu_op_e operator;
    word_t   operand_a;
    word_t   operand_b;
    tag_t    tag;
  } exu_req_t;

  // Issue to execute
  typedef struct packed {
    logic    valid;
    logic    alu_en;
    logic    mult_en;
    exu_op_e operator;
    word_t   operand_a;
    word_t   operand_b;
    tag_t    tag;
  } id_ex_pipe_t;

  // Execute to write-back
  typedef struct packed {
    logic  valid;
    tag_t  tag;
    word_t data;
    logic  cmp_flag;
  } ex_wb_pipe_t;

  // Output port payload, 38 bits
  typedef struct packed {
    tag_t  tag;
    word_t data;
    logic  cmp_flag;
  } exu_res_t;

endpackage

`default_nettype wire

/* hdl/exu_top.sv */
`default_nettype none

module exu_top
(
  input  logic              clk,
  input  logic              rst_n,

  // Operation request port
  input  logic              op_req_i,
  input  exu_pkg::exu_req_t op_i,
  output logic              op_ack_o,

  // Result port
  output logic              res_req_o,
  output exu_pkg::exu_res_t res_o,
  input  logic              res_ack_i
);

  // Stage to stage links
  exu_pkg::id_ex_pipe_t id_ex_pipe;
  exu_pkg::ex_wb_pipe_t ex_wb_pipe;
  logic                 ex_ready;
  logic                 wb_ready;

  exu_issue_stage i_issue
  (
    .clk          ( clk        ),
    .rst_n        ( rst_n      ),
    .op_req_i     ( op_req_i   ),
    .op_i         ( op_i       ),
    .op_ack_o     ( op_ack_o   ),
    .ex_ready_i   ( ex_ready   ),
    .id_ex_pipe_o ( id_ex_pipe )
  );

  exu_ex_stage i_ex
  (
    .clk          ( clk        ),
    .rst_n        ( rst_n      ),
    .id_ex_pipe_i ( id_ex_pipe ),
    .ex_ready_o   ( ex_ready   ),
    .wb_ready_i   ( wb_ready   ),
    .ex_wb_pipe_o ( ex_wb_pipe )
  );

  exu_wb_stage i_wb
  (
    .clk          ( clk        ),
    .rst_n        ( rst_n      ),
    .ex_wb_pipe_i ( ex_wb_pipe ),
    .wb_ready_o   ( wb_ready   ),
    .res_req_o    ( res_req_o  ),
    .res_o        ( res_o      ),
    .res_ack_i    ( res_ack_i  )
  );

endmodule

`default_nettype wire

/* hdl/exu_wb_stage.sv */
`default_nettype none

module exu_wb_stage
(
  input  logic                 clk,
  input  logic                 rst_n,

  // EX/WB pipeline
  input  exu_pkg::ex_wb_pipe_t ex_wb_pipe_i,
  output logic                 wb_ready_o,

  // Four-phase result port
  output logic                 res_req_o,
  output exu_pkg::exu_res_t    res_o,
  input  logic                 res_ack_i
);

  typedef enum logic [1:0] {EMPTY, REQ, WAIT_LOW} wb_state_e;

  wb_state_e         state_q;
  wb_state_e         state_d;
  logic              load;
  exu_pkg::exu_res_t buf_q;

  // Buffer only takes a result while empty
  assign load = (state_q == EMPTY) && ex_wb_pipe_i.valid;

  //////////////////////////////////////////////////
  // Four-phase send FSM
  //////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      EMPTY:    if (load) state_d = REQ;
      // Req held until the receiver acks
      REQ:      if (res_ack_i) state_d = WAIT_LOW;
      // Slot frees once ack is low again
      WAIT_LOW: if (!res_ack_i) state_d = EMPTY;
      default:  state_d = EMPTY;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= EMPTY;
    else
      state_q <= state_d;
  end

  always_ff @(posedge clk)
  begin
    if (load)
      buf_q <= '{tag: ex_wb_pipe_i.tag, data: ex_wb_pipe_i.data,
                 cmp_flag: ex_wb_pipe_i.cmp_flag};
  end

  assign wb_ready_o = (state_q == EMPTY);
  assign res_req_o  = (state_q == REQ);
  // Stable from load until release
  assign res_o      = buf_q;

endmodule

`default_nettype wire

/* verif/exu_tb.sv */
`default_nettype none

module exu_tb;

  timeunit 1ns;
  timeprecision 1ps;

  // Cycle limit of every handshake wait
  localparam int TIMEOUT_CYCLES = 1000;
  localparam int N_RANDOM       = 300;
  localparam int MAX_ACK_DELAY  = 40;
  // Issue slot, EX and WB each hold one operation
  localparam int PIPE_DEPTH     = 3;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              op_req_i;
  exu_pkg::exu_req_t op_i;
  logic              op_ack_o;
  logic              res_req_o;
  exu_pkg::exu_res_t res_o;
  logic              res_ack_i;

  logic [31:0]       rng_state = 32'd90775;
  exu_pkg::exu_req_t stim_q[$];
  exu_pkg::exu_res_t expect_q[$];
  int                gap_q[$];
  int                delay_q[$];

  // Port monitor state
  logic              prev_op_ack;
  logic              prev_res_req;
  logic              prev_res_ack;
  exu_pkg::exu_res_t prev_res;
  logic              req_armed;
  int                held;
  int                max_held;

  always #5 clk = ~clk;

  exu_top i_dut
  (
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .op_req_i  ( op_req_i  ),
    .op_i      ( op_i      ),
    .op_ack_o  ( op_ack_o  ),
    .res_req_o ( res_req_o ),
    .res_o     ( res_o     ),
    .res_ack_i ( res_ack_i )
  );

  //////////////////////////////////////////////////
  // Random source and reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic exu_pkg::exu_res_t expected_result(input exu_pkg::exu_req_t op);
    exu_pkg::exu_res_t res;
    logic [63:0]       wide_a;
    logic [63:0]       wide_b;
    logic [63:0]       prod;
    logic [4:0]        sh;
    res.tag      = op.tag;
    res.data     = '0;
    res.cmp_flag = 1'b0;
    sh           = op.operand_b[4:0];
    // Sign-extended copies for SRA and MULH
    wide_a = {{32{op.operand_a[31]}}, op.operand_a};
    wide_b = {{32{op.operand_b[31]}}, op.operand_b};
    case (op.operator)
      exu_pkg::ADD: res.data = op.operand_a + op.operand_b;
      exu_pkg::SUB: res.data = op.operand_a + ~op.operand_b + 32'd1;
      exu_pkg::AND: res.data = op.operand_a & op.operand_b;
      exu_pkg::OR:  res.data = op.operand_a | op.operand_b;
      exu_pkg::XOR: res.data = op.operand_a ^ op.operand_b;
      exu_pkg::SLL: res.data = op.operand_a << sh;
      exu_pkg::SRL: res.data = op.operand_a >> sh;
      exu_pkg::SRA:
      begin
        prod     = wide_a >> sh;
        res.data = prod[31:0];
      end
      // Differing signs decide alone, else plain magnitude order
      exu_pkg::SLT:
      begin
        res.cmp_flag = (op.operand_a[31] != op.operand_b[31]) ? op.operand_a[31]
                                                               : (op.operand_a < op.operand_b);
        res.data     = {31'b0, res.cmp_flag};
      end
      exu_pkg::SLTU:
      begin
        res.cmp_flag = op.operand_a < op.operand_b;
        res.data     = {31'b0, res.cmp_flag};
      end
      exu_pkg::EQ:
      begin
        res.cmp_flag = op.operand_a == op.operand_b;
        res.data     = {31'b0, res.cmp_flag};
      end
      exu_pkg::MUL:
      begin
        prod     = {32'b0, op.operand_a} * {32'b0, op.operand_b};
        res.data = prod[31:0];
      end
      // Low 64 bits of the sign-extended product equal the signed product
      exu_pkg::MULH:
      begin
        prod     = wide_a * wide_b;
        res.data = prod[63:32];
      end
      exu_pkg::MULHU:
      begin
        prod     = {32'b0, op.operand_a} * {32'b0, op.operand_b};
        res.data = prod[63:32];
      end
      default: res.data = '0;
    endcase
    return res;
  endfunction

  //////////////////////////////////////////////////
  // Checks and handshake tasks
  //////////////////////////////////////////////////

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected)
      report_failure($sformatf("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual));
  endtask

  task automatic wait_op_ack(input logic level);
    int cycles;
    cycles = 0;
    do
    begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES)
        report_failure($sformatf("Timeout: op_ack_o never went to %0b on the request port", level));
    end
    while (op_ack_o !== level);
  endtask

  task automatic wait_res_req(input logic level);
    int cycles;
    cycles = 0;
    do
    begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES)
        report_failure($sformatf("Timeout: res_req_o never went to %0b on the result port", level));
    end
    while (res_req_o !== level);
  endtask

  // Called just after a rising edge with req and ack both low
  task automatic send_op(input exu_pkg::exu_req_t op);
    op_i     <= op;
    op_req_i <= 1'b1;
    wait_op_ack(1'b1);
    expect_q.push_back(expected_result(op));
    op_req_i <= 1'b0;
    wait_op_ack(1'b0);
  endtask

  task automatic receive_result(input int ack_delay);
    exu_pkg::exu_res_t expected;
    wait_res_req(1'b1);
    if (expect_q.size() == 0)
      report_failure("A result arrived with no operation outstanding");
    else
    begin
      expected = expect_q.pop_front();
      check_value("res_o.tag", expected.tag, res_o.tag);
      check_value("res_o.data", expected.data, res_o.data);
      check_value("res_o.cmp_flag", expected.cmp_flag, res_o.cmp_flag);
      // Back-pressure by holding the ack back
      repeat (ack_delay) @(posedge clk);
      res_ack_i <= 1'b1;
      wait_res_req(1'b0);
      res_ack_i <= 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // Four-phase rules and occupancy monitor
  //////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      held      = 0;
      max_held  = 0;
      req_armed = 1'b1;
    end
    else
    begin
      if (op_ack_o && !prev_op_ack && !op_req_i)
        report_failure("op_ack_o rose while op_req_i was low");
      if (!res_ack_i && prev_res_ack)
        req_armed = 1'b1;
      if (res_req_o && !prev_res_req)
      begin
        if (!req_armed)
          report_failure("res_req_o rose again before res_ack_i fell");
        req_armed = 1'b0;
      end
      if (res_req_o && prev_res_req && (res_o !== prev_res))
        report_failure("res_o changed while res_req_o was high");
      // An operation counts from its ack until the WB slot frees
      if (op_ack_o && !prev_op_ack)
        held++;
      if (!res_ack_i && prev_res_ack)
        held--;
      if (held > PIPE_DEPTH)
        report_failure("op_ack_o was given while the pipeline was already full");
      if (held > max_held)
        max_held = held;
    end
    prev_op_ack  = op_ack_o;
    prev_res_req = res_req_o;
    prev_res_ack = res_ack_i;
    prev_res     = res_o;
  end

  //////////////////////////////////////////////////
  // Stimulus and sequencing
  //////////////////////////////////////////////////

  initial
  begin
    exu_pkg::word_t    corner_vals [6];
    exu_pkg::exu_req_t op;
    logic [31:0]       r;
    logic [31:0]       op_sel;
    op_req_i  = 1'b0;
    op_i      = '0;
    res_ack_i = 1'b0;
    rst_n     = 1'b0;
    // Zero, all ones, sign bit, max positive, one, shift amount 31
    corner_vals = '{32'h0000_0000, 32'hFFFF_FFFF, 32'h8000_0000,
                    32'h7FFF_FFFF, 32'h0000_0001, 32'h0000_001F};

    // Every operator on all corner pairs
    for (int k = 0; k < 14; k++)
    begin
      foreach (corner_vals[a])
      begin
        foreach (corner_vals[b])
        begin
          r            = next_random();
          op.operator  = exu_pkg::exu_op_e'(k[3:0]);
          op.operand_a = corner_vals[a];
          op.operand_b = corner_vals[b];
          op.tag       = r[4:0];
          stim_q.push_back(op);
        end
      end
    end

    // Mixed random stream
    repeat (N_RANDOM)
    begin
      r            = next_random();
      op_sel       = r % 32'd14;
      op.operator  = exu_pkg::exu_op_e'(op_sel[3:0]);
      op.operand_a = next_random();
      op.operand_b = next_random();
      r            = next_random();
      op.tag       = r[4:0];
      stim_q.push_back(op);
    end

    // Request gaps, half of them back to back, and ack delays
    foreach (stim_q[n])
    begin
      r = next_random();
      gap_q.push_back(r[1] ? 0 : int'(r[3:2]));
      delay_q.push_back(int'(r[31:16] % 16'(MAX_ACK_DELAY + 1)));
    end

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // Both ports stay quiet while nothing is requested
    repeat (5)
    begin
      @(posedge clk);
      check_value("op_ack_o", 1'b0, op_ack_o);
      check_value("res_req_o", 1'b0, res_req_o);
    end

    fork
      begin : drive_ops
        foreach (stim_q[n])
        begin
          send_op(stim_q[n]);
          repeat (gap_q[n]) @(posedge clk);
        end
      end
      begin : collect_results
        foreach (delay_q[n])
          receive_result(delay_q[n]);
      end
    join

    // Nothing may follow the last result
    repeat (50)
    begin
      @(posedge clk);
      check_value("res_req_o", 1'b0, res_req_o);
    end

    if (max_held != PIPE_DEPTH)
      report_failure("The pipeline never filled up under back-pressure");
    else
    begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
